// ==== include/exp_macros.svh ====
//////////////////////////////
// Word format is fixed Q8.24 signed
// Term count must stay within the ROM table and index width
//////////////////////////////
`ifndef EXP_MACROS_SVH
`define EXP_MACROS_SVH

// Data word width
`define EXP_DATA_SIZE 32
// Fraction bits of the Q8.24 word
`define EXP_FRAC_BITS 24
// Series terms after the constant 1
`define EXP_TERMS 12
// Width of the term index
`define EXP_IDX_SIZE 4
// Integer field at or above this saturates at load
`define EXP_MAX_INT 5

`endif

// ==== hdl/exp_pkg.sv ====
//////////////////////////////
// Types shared by the exponentiator blocks
// Field widths follow the word format macros
//////////////////////////////
package exp_pkg;

  `include "exp_macros.svh"

  // Q8.24 word split into integer and fraction
  typedef struct packed {
    logic signed [`EXP_DATA_SIZE-`EXP_FRAC_BITS-1:0] int_part;
    logic        [`EXP_FRAC_BITS-1:0]                frac_part;
  } exp_fix_t;

  // Same word seen as a raw number or as fields
  typedef union packed {
    logic signed [`EXP_DATA_SIZE-1:0] raw;
    exp_fix_t                         fix;
  } exp_word_t;

  // Strobes from the controller
  typedef struct packed {
    logic load;
    logic step;
    logic finish;
  } exp_ctrl_t;

  // Registered result towards the top-level ports
  typedef struct packed {
    logic [`EXP_DATA_SIZE-1:0] data;
    logic                      overflow;
  } exp_result_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } exp_state_t;

endpackage

// ==== hdl/exp_ctrl_fsm.sv ====
//////////////////////////////
// START is accepted only in IDLE, later pulses are dropped
// READY is a registered one-cycle strobe
//////////////////////////////
`timescale 1ns/1ns

module exp_ctrl_fsm
  import exp_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      START,
  input  logic      last,
  output exp_ctrl_t ctrl,
  output logic      READY
);

  //////////////////////////////
  // State
  //////////////////////////////

  exp_state_t state_q;
  exp_state_t state_d;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // Wait for an operand
        if (START) begin
          state_d = RUN;
        end
      end
      RUN: begin
        // Leave once the last term is summed
        if (last) begin
          state_d = DONE;
        end
      end
      DONE: begin
        // One cycle to publish the result
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // State register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////
  // Strobes
  //////////////////////////////

  // Load only on the START cycle in IDLE
  assign ctrl.load   = (state_q == IDLE) && START;
  // One term per RUN cycle
  assign ctrl.step   = (state_q == RUN);
  // Output registers capture in DONE
  assign ctrl.finish = (state_q == DONE);

  // READY lines up with the datapath output registers
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= ctrl.finish;
    end
  end

endmodule

// ==== hdl/exp_term_counter.sv ====
//////////////////////////////
// Index runs 1 to EXP_TERMS during a run
// Past the last step it holds a value the ROM maps to zero
//////////////////////////////
`timescale 1ns/1ns

`include "exp_macros.svh"

module exp_term_counter
  import exp_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,
  input  exp_ctrl_t                ctrl,
  output logic [`EXP_IDX_SIZE-1:0] index,
  output logic                     last
);

  // First term index
  localparam logic [`EXP_IDX_SIZE-1:0] FIRST_IDX = `EXP_IDX_SIZE'd1;

  // Index register
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      index <= FIRST_IDX;
    end else if (ctrl.load) begin
      // Restart the series at term 1
      index <= FIRST_IDX;
    end else if (ctrl.step) begin
      index <= index + `EXP_IDX_SIZE'd1;
    end
  end

  // High during the step that adds the final term
  assign last = ctrl.step && (index == `EXP_IDX_SIZE'(`EXP_TERMS));

endmodule

// ==== hdl/exp_recip_rom.sv ====
//////////////////////////////
// floor(2^24/k) in Q1.24 for k = 1 to 12
// Any other index returns zero
//////////////////////////////
`timescale 1ns/1ns

`include "exp_macros.svh"

module exp_recip_rom
  import exp_pkg::*;
(
  input  logic [`EXP_IDX_SIZE-1:0] index,
  output exp_word_t                recip
);

  // Reciprocal table, no clock
  always_comb begin
    case (index)
      // Exactly 1.0
      `EXP_IDX_SIZE'd1:  recip.raw = 32'sh0100_0000;
      `EXP_IDX_SIZE'd2:  recip.raw = 32'sh0080_0000;
      `EXP_IDX_SIZE'd3:  recip.raw = 32'sh0055_5555;
      `EXP_IDX_SIZE'd4:  recip.raw = 32'sh0040_0000;
      `EXP_IDX_SIZE'd5:  recip.raw = 32'sh0033_3333;
      `EXP_IDX_SIZE'd6:  recip.raw = 32'sh002A_AAAA;
      `EXP_IDX_SIZE'd7:  recip.raw = 32'sh0024_9249;
      `EXP_IDX_SIZE'd8:  recip.raw = 32'sh0020_0000;
      `EXP_IDX_SIZE'd9:  recip.raw = 32'sh001C_71C7;
      `EXP_IDX_SIZE'd10: recip.raw = 32'sh0019_9999;
      `EXP_IDX_SIZE'd11: recip.raw = 32'sh0017_45D1;
      `EXP_IDX_SIZE'd12: recip.raw = 32'sh0015_5555;
      // Unused indices
      default:           recip.raw = 32'sh0000_0000;
    endcase
  end

endmodule

// ==== hdl/exp_series_datapath.sv ====
//////////////////////////////
// Products are truncated by arithmetic shift, no rounding
// No range reduction, results past 127.99 saturate
//////////////////////////////
`timescale 1ns/1ns

`include "exp_macros.svh"

module exp_series_datapath
  import exp_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  exp_ctrl_t   ctrl,
  input  exp_word_t   data_in,
  input  exp_word_t   recip,
  output exp_result_t result
);

  localparam int W = `EXP_DATA_SIZE;

  // 1.0 in Q8.24
  localparam logic signed [W-1:0] ONE_Q = 32'sd1 <<< `EXP_FRAC_BITS;
  // Largest positive word
  localparam logic [W-1:0] SAT_Q = {1'b0, {(W-1){1'b1}}};

  //////////////////////////////
  // Registers
  //////////////////////////////

  logic signed [W-1:0] x_q;
  logic signed [W-1:0] term_q;
  logic signed [W-1:0] sum_q;
  logic                ovf_q;

  //////////////////////////////
  // Term arithmetic
  //////////////////////////////

  logic signed [2*W-1:0] p_full;
  logic signed [2*W-1:0] t_full;
  logic signed [W-1:0]   p_word;
  logic signed [W-1:0]   term_next;
  logic signed [W:0]     sum_wide;
  logic                  p_ovf;
  logic                  t_ovf;
  logic                  s_ovf;
  logic                  early_ovf;

  // term * x, back to Q8.24
  assign p_full = (term_q * x_q) >>> `EXP_FRAC_BITS;
  assign p_word = p_full[W-1:0];
  // Upper bits must all copy the sign
  assign p_ovf  = (p_full[2*W-1:W-1] != {(W+1){p_full[W-1]}});

  // Divide by k through the reciprocal
  assign t_full    = (p_word * $signed(recip.raw)) >>> `EXP_FRAC_BITS;
  assign term_next = t_full[W-1:0];
  assign t_ovf     = (t_full[2*W-1:W-1] != {(W+1){t_full[W-1]}});

  // Running sum with one guard bit
  assign sum_wide = sum_q + term_next;
  assign s_ovf    = (sum_wide[W] != sum_wide[W-1]);

  // Integer field alone decides the early check
  assign early_ovf = ($signed(data_in.fix.int_part) >= `EXP_MAX_INT);

  // Operand, term and sum
  always_ff @(posedge CLK) begin
    if (ctrl.load) begin
      x_q    <= data_in.raw;
      term_q <= ONE_Q;
      sum_q  <= ONE_Q;
    end else if (ctrl.step) begin
      term_q <= term_next;
      sum_q  <= sum_wide[W-1:0];
    end
  end

  // Sticky overflow for the run
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ovf_q <= 1'b0;
    end else if (ctrl.load) begin
      ovf_q <= early_ovf;
    end else if (ctrl.step) begin
      ovf_q <= ovf_q | p_ovf | t_ovf | s_ovf;
    end
  end

  //////////////////////////////
  // Output registers
  //////////////////////////////

  // Hold until the next finish
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result <= '0;
    end else if (ctrl.finish) begin
      result.data     <= ovf_q ? SAT_Q : sum_q;
      result.overflow <= ovf_q;
    end
  end

endmodule

// ==== hdl/scalar_exponentiator.sv ====
//////////////////////////////
// One operand in flight, START while busy is ignored
// READY follows an accepted START by 13 cycles
//////////////////////////////
`timescale 1ns/1ns

`include "exp_macros.svh"

module scalar_exponentiator
  import exp_pkg::*;
(
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  logic [`EXP_DATA_SIZE-1:0] DATA_IN,
  output logic                      READY,
  output logic [`EXP_DATA_SIZE-1:0] DATA_OUT,
  output logic                      OVERFLOW_OUT
);

  // Controller strobes
  exp_ctrl_t                ctrl;
  // Term index and its end flag
  logic [`EXP_IDX_SIZE-1:0] index;
  logic                     last;
  // Reciprocal for the current index
  exp_word_t                recip;
  // Registered result
  exp_result_t              result;

  exp_ctrl_fsm u_ctrl_fsm (
    .CLK   (CLK),
    .RST   (RST),
    .START (START),
    .last  (last),
    .ctrl  (ctrl),
    .READY (READY)
  );

  exp_term_counter u_term_counter (
    .CLK   (CLK),
    .RST   (RST),
    .ctrl  (ctrl),
    .index (index),
    .last  (last)
  );

  exp_recip_rom u_recip_rom (
    .index (index),
    .recip (recip)
  );

  exp_series_datapath u_series_datapath (
    .CLK     (CLK),
    .RST     (RST),
    .ctrl    (ctrl),
    .data_in (DATA_IN),
    .recip   (recip),
    .result  (result)
  );

  // Result fields onto the ports
  assign DATA_OUT     = result.data;
  assign OVERFLOW_OUT = result.overflow;

endmodule

// ==== dv/scalar_exponentiator_props.sv ====
//////////////////////////////
// Bound into scalar_exponentiator, reads ports and ctrl strobes
// Latency checks assume the fixed EXP_TERMS run length
//////////////////////////////
`timescale 1ns/1ns

`include "exp_macros.svh"

module scalar_exponentiator_props
  import exp_pkg::*;
(
  input logic                      CLK,
  input logic                      RST,
  input exp_ctrl_t                 ctrl,
  input logic                      READY,
  input logic [`EXP_DATA_SIZE-1:0] DATA_OUT,
  input logic                      OVERFLOW_OUT
);

  // Sampled load to sampled READY, in clock edges
  localparam int READY_LAT = `EXP_TERMS + 2;

  // Set once the first operand is accepted
  logic started;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      started <= 1'b0;
    end else if (ctrl.load) begin
      started <= 1'b1;
    end
  end

  // Reset values until the first START
  idle_after_reset: assert property (@(posedge CLK) disable iff (RST)
    !started |-> (!READY && DATA_OUT == '0 && !OVERFLOW_OUT))
    else $error("outputs left their reset values before any START");

  // READY exactly when a load lies READY_LAT edges back
  ready_latency: assert property (@(posedge CLK) disable iff (RST)
    READY == $past(ctrl.load, READY_LAT))
    else $error("MISMATCH READY got %h expected %h", READY, !READY);

  // Single-cycle strobe
  ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY)
    else $error("READY stayed high for more than one cycle");

  // Outputs only move together with READY
  result_hold: assert property (@(posedge CLK) disable iff (RST)
    !READY |-> ($stable(DATA_OUT) && $stable(OVERFLOW_OUT)))
    else $error("DATA_OUT or OVERFLOW_OUT changed while READY was low");

endmodule

// ==== dv/scalar_exponentiator_tb.sv ====
//////////////////////////////
// Operands stay inside the 12-term series range, no range reduction
// One operand in flight at a time, result checked on each READY
//////////////////////////////
`timescale 1ns/1ns

`include "exp_macros.svh"

module scalar_exponentiator_tb
  import exp_pkg::*;
;

  localparam int CLK_PERIOD  = 100;
  localparam int NUM_RANDOM  = 28;
  localparam int NUM_LARGE   = 5;
  localparam int NUM_NEAR    = 3;
  localparam int NUM_BUSY    = 4;
  localparam int NUM_OPS     = NUM_RANDOM + NUM_LARGE + NUM_NEAR + NUM_BUSY;
  // Cycles budgeted per operation
  // Busy ops add a watch for a stray READY
  localparam int OP_CYCLES   = 16;
  localparam int WATCHDOG_NS = (NUM_OPS + NUM_BUSY) * OP_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD;
  localparam logic [31:0] LFSR_SEED = 32'h52df_3614;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                      CLK;
  logic                      RST;
  logic                      START;
  logic [`EXP_DATA_SIZE-1:0] DATA_IN;
  logic                      READY;
  logic [`EXP_DATA_SIZE-1:0] DATA_OUT;
  logic                      OVERFLOW_OUT;

  logic [31:0]               lfsr;
  exp_result_t               expect_q[$];

  scalar_exponentiator DUT (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .DATA_IN      (DATA_IN),
    .READY        (READY),
    .DATA_OUT     (DATA_OUT),
    .OVERFLOW_OUT (OVERFLOW_OUT)
  );

  bind scalar_exponentiator scalar_exponentiator_props u_props (
    .CLK          (CLK),
    .RST          (RST),
    .ctrl         (ctrl),
    .READY        (READY),
    .DATA_OUT     (DATA_OUT),
    .OVERFLOW_OUT (OVERFLOW_OUT)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic bit fits_word(input longint v);
    return (v >= -(longint'(1) <<< 31)) && (v < (longint'(1) <<< 31));
  endfunction

  // Keep the low 32 bits as a signed value
  function automatic longint wrap_word(input longint v);
    return longint'($signed(v[31:0]));
  endfunction

  // Taylor series in 64-bit math, truncating shifts, sticky overflow
  function automatic exp_result_t model_exp(input logic [31:0] x);
    exp_result_t r;
    longint      xs;
    longint      term;
    longint      sum;
    longint      p;
    longint      t;
    longint      recip;
    logic        ovf;
    xs   = longint'($signed(x));
    ovf  = ($signed(x[31:24]) >= `EXP_MAX_INT);
    term = longint'(1) <<< `EXP_FRAC_BITS;
    sum  = term;
    for (int k = 1; k <= `EXP_TERMS; k++) begin
      recip = (longint'(1) <<< `EXP_FRAC_BITS) / k;
      p     = (term * xs) >>> `EXP_FRAC_BITS;
      ovf   = ovf | !fits_word(p);
      t     = (wrap_word(p) * recip) >>> `EXP_FRAC_BITS;
      ovf   = ovf | !fits_word(t);
      term  = wrap_word(t);
      sum   = sum + term;
      ovf   = ovf | !fits_word(sum);
      sum   = wrap_word(sum);
    end
    r.data     = ovf ? 32'h7FFF_FFFF : sum[31:0];
    r.overflow = ovf;
    return r;
  endfunction

  // Issue one START, optionally poke START again mid-run, check on READY
  task automatic run_op(input logic [31:0] x, input logic [31:0] x_busy, input bit poke_busy);
    exp_result_t want;
    int          waited;
    expect_q.push_back(model_exp(x));
    @(posedge CLK);
    START   <= 1'b1;
    DATA_IN <= x;
    @(posedge CLK);
    START   <= 1'b0;
    if (poke_busy) begin
      // FSM is in RUN here
      repeat (3) @(posedge CLK);
      START   <= 1'b1;
      DATA_IN <= x_busy;
      @(posedge CLK);
      START   <= 1'b0;
    end
    waited = 0;
    @(negedge CLK);
    while (!READY) begin
      waited++;
      if (waited > OP_CYCLES) begin
        abort_run("READY never came after an accepted START");
      end
      @(negedge CLK);
    end
    want = expect_q.pop_front();
    assert (DATA_OUT == want.data) else
      abort_run($sformatf("MISMATCH DATA_OUT got %h expected %h (x %h)", DATA_OUT, want.data, x));
    assert (OVERFLOW_OUT == want.overflow) else
      abort_run($sformatf("MISMATCH OVERFLOW_OUT got %h expected %h (x %h)",
                          OVERFLOW_OUT, want.overflow, x));
    if (poke_busy) begin
      // Second START was dropped, so no further READY
      repeat (OP_CYCLES) begin
        @(negedge CLK);
        assert (!READY) else abort_run("extra READY after a START given while busy");
      end
    end
  endtask

  // No unknowns on the outputs once out of reset
  outputs_known: assert property (@(posedge CLK) disable iff (RST)
    !$isunknown({READY, DATA_OUT, OVERFLOW_OUT}))
    else abort_run("DUT outputs went unknown after reset");

  //////////////////////////////
  // Clock, watchdog, stimulus
  //////////////////////////////

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before all operations finished");
  end

  initial begin
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] frac;
    logic [7:0]  int_f;
    RST         = 1'b1;
    START       = 1'b0;
    DATA_IN     = '0;
    lfsr        = LFSR_SEED;
    repeat (3) @(posedge CLK);
    RST <= 1'b0;
    // Idle stretch so reset values get checked
    repeat (4) @(posedge CLK);
    // Both signs in [-4, 4)
    repeat (NUM_RANDOM) begin
      x = {5'b0, 27'(random_bits(27))} - 32'h0400_0000;
      run_op(x, '0, 1'b0);
    end
    // Integer field 5 or more, early saturation
    repeat (NUM_LARGE) begin
      int_f = 8'd5 + 8'(random_bits(6));
      frac  = random_bits(24);
      x     = {int_f, frac[23:0]};
      run_op(x, '0, 1'b0);
    end
    // Just under 5, sum runs past 127.99
    repeat (NUM_NEAR) begin
      x = 32'h04E6_6666 + random_bits(20);
      run_op(x, '0, 1'b0);
    end
    // START during RUN must be ignored
    repeat (NUM_BUSY) begin
      x = {5'b0, 27'(random_bits(27))} - 32'h0400_0000;
      y = {5'b0, 27'(random_bits(27))} - 32'h0400_0000;
      run_op(x, y, 1'b1);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== scalar_exponentiator.f ====
+incdir+include
hdl/exp_pkg.sv
hdl/exp_ctrl_fsm.sv
hdl/exp_term_counter.sv
hdl/exp_recip_rom.sv
hdl/exp_series_datapath.sv
hdl/scalar_exponentiator.sv
dv/scalar_exponentiator_props.sv
dv/scalar_exponentiator_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the exponentiator testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module scalar_exponentiator_tb -f scalar_exponentiator.f -o sim_exp
# The log decides the outcome, not the exit code
./obj_dir/sim_exp > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "TEST RESULT: PASS" sim.log
